//--- tests/ht_stim.txt
// test op key      value code exp_value, all hex, op 0 search 1 insert
// code 0 found, 1 not found, 2 inserted, 3 updated, 4 table full
01 0 12345678 0000 1 0000
01 0 deadbeef 0000 1 0000
01 0 00000000 0000 1 0000
02 1 12345678 a5a5 2 a5a5
02 0 12345678 0000 0 a5a5
02 1 cafef00d 1234 2 1234
02 0 cafef00d 0000 0 1234
02 0 12345679 0000 1 0000
03 1 12345678 5a5a 3 5a5a
03 0 12345678 0000 0 5a5a
03 0 cafef00d 0000 0 1234
// keys below all fold to bucket 0
04 1 00000011 0011 2 0011
04 1 00000022 0022 2 0022
04 1 00000033 0033 2 0033
04 1 11000000 1100 2 1100
04 1 abcd0000 abcd 2 abcd
04 0 00000011 0000 0 0011
04 0 00000022 0000 0 0022
04 0 00000033 0000 0 0033
04 0 11000000 0000 0 1100
04 0 abcd0000 0000 0 abcd
04 1 00000022 2222 3 2222
04 0 00000022 0000 0 2222
04 0 00000044 0000 1 0000
04 0 00000011 0000 0 0011
// end of list
00 0 00000000 0000 0 0000

//--- ht_top.f
+incdir+verilog
verilog/ht_pkg.sv
verilog/ht_dp_ram.sv
verilog/ht_hash_decode.sv
verilog/ht_head_table.sv
verilog/ht_data_table.sv
verilog/ht_result.sv
verilog/ht_top.sv
tests/ht_top_chk.sv
tests/tb_ht_top.sv

//--- Bender.yml
package:
  name: ht_top

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/ht_pkg.sv
      - verilog/ht_dp_ram.sv
      - verilog/ht_hash_decode.sv
      - verilog/ht_head_table.sv
      - verilog/ht_data_table.sv
      - verilog/ht_result.sv
      - verilog/ht_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/ht_top_chk.sv
      - tests/tb_ht_top.sv

//--- tests/tb_ht_top.sv
`timescale 1ns/1ps
`include "ht_cfg.svh"

module tb_ht_top;

  localparam int TIMEOUT   = 200;
  localparam int STIM_ROWS = 64;
  localparam int ENTRIES   = 1 << `HT_ADDR_W;

  logic              clk_i;
  logic              rst_i;
  ht_pkg::ht_cmd_t   cmd_i;
  logic              cmd_valid_i;
  logic              cmd_ready_o;
  ht_pkg::ht_res_t   res_o;
  logic              res_valid_o;
  logic              clear_run_i;
  logic              clear_done_o;
  ht_pkg::ht_stats_t stats_o;

  // six words per row in the order of the file columns
  logic [31:0] stim_mem [0:6*STIM_ROWS-1];
  integer      seed = 32'ha796;
  int          errors;
  int          checks;
  int          tests;
  logic        stalled;
  int          code_count [0:4];

  ht_top dut_i (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .cmd_i        ( cmd_i        ),
    .cmd_valid_i  ( cmd_valid_i  ),
    .cmd_ready_o  ( cmd_ready_o  ),
    .res_o        ( res_o        ),
    .res_valid_o  ( res_valid_o  ),
    .clear_run_i  ( clear_run_i  ),
    .clear_done_o ( clear_done_o ),
    .stats_o      ( stats_o      )
  );

  bind ht_top ht_top_chk chk_i (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .cmd_valid_i  ( cmd_valid_i  ),
    .cmd_ready_o  ( cmd_ready_o  ),
    .res_valid_o  ( res_valid_o  ),
    .clear_run_i  ( clear_run_i  ),
    .clear_done_o ( clear_done_o )
  );

  initial
  begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic report_test(input int num, input int errs);
    tests++;
    $display("test %0d finished with %0d errors", num, errs);
  endtask

  // ==========================================================================
  // bus drivers
  // ==========================================================================

  task automatic run_cmd(input logic op, input logic [31:0] key, input logic [15:0] value,
                         output ht_pkg::ht_res_t res);
    int cycles;
    cycles = 0;
    res    = '0;
    @(negedge clk_i);
    while (!cmd_ready_o && cycles < TIMEOUT)
    begin
      @(negedge clk_i);
      cycles++;
    end
    if (!cmd_ready_o)
    begin
      $display("Timeout: cmd_ready_o stayed low for %0d cycles", TIMEOUT);
      errors++;
      stalled = 1'b1;
    end
    else
    begin
      @(posedge clk_i);
      cmd_i       <= '{opcode: ht_pkg::ht_opcode_e'(op), key: key, value: value};
      cmd_valid_i <= 1'b1;
      @(posedge clk_i);
      cmd_valid_i <= 1'b0;
      cycles = 0;
      @(negedge clk_i);
      while (!res_valid_o && cycles < TIMEOUT)
      begin
        @(negedge clk_i);
        cycles++;
      end
      if (!res_valid_o)
      begin
        $display("Timeout: no result came back for key %h", key);
        errors++;
        stalled = 1'b1;
      end
      else
        res = res_o;
    end
  endtask

  task automatic do_vector(input logic op, input logic [31:0] key, input logic [15:0] value,
                           input logic [2:0] exp_code, input logic [15:0] exp_value);
    ht_pkg::ht_res_t res;
    if (!stalled)
    begin
      run_cmd(op, key, value, res);
      code_count[exp_code]++;
      if (!stalled)
      begin
        check_value("res_o.opcode", res.opcode, op);
        check_value("res_o.key", res.key, key);
        check_value("res_o.code", res.code, exp_code);
        check_value("res_o.value", res.value, exp_value);
      end
    end
  endtask

  task automatic clear_table();
    int cycles;
    if (!stalled)
    begin
      @(posedge clk_i);
      clear_run_i <= 1'b1;
      @(posedge clk_i);
      clear_run_i <= 1'b0;
      cycles = 0;
      @(negedge clk_i);
      while (!clear_done_o && cycles < TIMEOUT)
      begin
        @(negedge clk_i);
        cycles++;
      end
      if (!clear_done_o)
      begin
        $display("Timeout: clear_done_o never pulsed after a clear request");
        errors++;
        stalled = 1'b1;
      end
    end
  endtask

  // ==========================================================================
  // tests
  // ==========================================================================

  task automatic run_stim_file();
    int          row;
    int          cur_test;
    int          err_start;
    logic [31:0] num;
    row       = 0;
    cur_test  = 0;
    err_start = errors;
    $readmemh("tests/ht_stim.txt", stim_mem);
    if (^stim_mem[0] === 1'bx || stim_mem[0] == 0)
    begin
      $display("Could not read any vectors from tests/ht_stim.txt");
      errors++;
    end
    // a row with test number zero ends the list
    while (row < STIM_ROWS && ^stim_mem[6*row] !== 1'bx && stim_mem[6*row] != 0)
    begin
      num = stim_mem[6*row];
      if (num != cur_test)
      begin
        if (cur_test != 0)
          report_test(cur_test, errors - err_start);
        cur_test  = num;
        err_start = errors;
      end
      do_vector(stim_mem[6*row+1][0], stim_mem[6*row+2], stim_mem[6*row+3][15:0],
                stim_mem[6*row+4][2:0], stim_mem[6*row+5][15:0]);
      row++;
    end
    if (cur_test != 0)
      report_test(cur_test, errors - err_start);
  endtask

  task automatic fill_test();
    logic [31:0] keys [0:ENTRIES];
    logic [31:0] k;
    logic        dup;
    logic [2:0]  exp_code;
    logic [15:0] exp_value;
    int          err_start;
    err_start = errors;
    for (int i = 0; i <= ENTRIES; i++)
    begin
      dup = 1'b1;
      while (dup)
      begin
        k   = $random(seed);
        dup = 1'b0;
        for (int j = 0; j < i; j++)
          if (keys[j] == k)
            dup = 1'b1;
      end
      keys[i] = k;
    end
    clear_table();
    // allocator has room for ENTRIES new keys only
    for (int i = 0; i <= ENTRIES; i++)
    begin
      exp_code  = (i < ENTRIES) ? ht_pkg::INSERTED : ht_pkg::TABLE_FULL;
      exp_value = (i < ENTRIES) ? keys[i][15:0] : 16'h0000;
      do_vector(1'b1, keys[i], keys[i][15:0], exp_code, exp_value);
    end
    do_vector(1'b0, keys[0], 16'h0000, ht_pkg::FOUND, keys[0][15:0]);
    do_vector(1'b0, keys[ENTRIES], 16'h0000, ht_pkg::NOT_FOUND, 16'h0000);
    clear_table();
    for (int i = 0; i < ENTRIES; i++)
      do_vector(1'b0, keys[i], 16'h0000, ht_pkg::NOT_FOUND, 16'h0000);
    do_vector(1'b1, keys[ENTRIES], 16'hbeef, ht_pkg::INSERTED, 16'hbeef);
    do_vector(1'b0, keys[ENTRIES], 16'h0000, ht_pkg::FOUND, 16'hbeef);
    report_test(5, errors - err_start);
  endtask

  task automatic check_stats();
    int err_start;
    err_start = errors;
    @(negedge clk_i);
    check_value("stats_o.hits", stats_o.hits, code_count[ht_pkg::FOUND]);
    check_value("stats_o.misses", stats_o.misses, code_count[ht_pkg::NOT_FOUND]);
    // updates land in the insert counter too
    check_value("stats_o.inserts", stats_o.inserts,
                code_count[ht_pkg::INSERTED] + code_count[ht_pkg::UPDATED]);
    check_value("stats_o.fulls", stats_o.fulls, code_count[ht_pkg::TABLE_FULL]);
    report_test(6, errors - err_start);
  endtask

  initial
  begin
    rst_i       = 1'b1;
    cmd_i       = '0;
    cmd_valid_i = 1'b0;
    clear_run_i = 1'b0;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    stalled     = 1'b0;
    for (int i = 0; i < 5; i++)
      code_count[i] = 0;
    repeat (8) @(posedge clk_i);
    rst_i <= 1'b0;
    // head table holds garbage until swept
    clear_table();
    run_stim_file();
    fill_test();
    check_stats();
    errors += dut_i.chk_i.fail_count;
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

//--- tests/ht_top_chk.sv
`timescale 1ns/1ps
`include "ht_cfg.svh"

module ht_top_chk (
  input logic clk_i,
  input logic rst_i,
  input logic cmd_valid_i,
  input logic cmd_ready_o,
  input logic res_valid_o,
  input logic clear_run_i,
  input logic clear_done_o
);

  localparam int SWEEP = 1 << `HT_BUCKET_W;

  logic in_flight_q;
  int   fail_count = 0;

  // accepted command still waiting for its result
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      in_flight_q <= 1'b0;
    else if (cmd_valid_i && cmd_ready_o)
      in_flight_q <= 1'b1;
    else if (res_valid_o)
      in_flight_q <= 1'b0;
  end

  single_res: assert property (@(posedge clk_i) disable iff (rst_i)
    res_valid_o |=> !res_valid_o)
  else
  begin
    fail_count++;
    $error("res_valid_o high for two cycles in a row");
  end

  ready_held: assert property (@(posedge clk_i) disable iff (rst_i)
    in_flight_q && !res_valid_o |-> !cmd_ready_o)
  else
  begin
    fail_count++;
    $error("cmd_ready_o rose before the result of the accepted command");
  end

  // done stays low through the sweep and pulses on its last bucket
  clear_len: assert property (@(posedge clk_i) disable iff (rst_i)
    clear_run_i |=> !clear_done_o [*SWEEP-1] ##1 clear_done_o)
  else
  begin
    fail_count++;
    $error("clear_done_o not exactly one sweep after clear_run_i");
  end

endmodule

//--- verilog/ht_top.sv
`timescale 1ns/1ps
`include "ht_cfg.svh"

module ht_top (
  input  logic              clk_i,
  input  logic              rst_i,

  input  ht_pkg::ht_cmd_t   cmd_i,
  input  logic              cmd_valid_i,
  output logic              cmd_ready_o,

  output ht_pkg::ht_res_t   res_o,
  output logic              res_valid_o,

  input  logic              clear_run_i,
  output logic              clear_done_o,

  output ht_pkg::ht_stats_t stats_o
);

  ht_pkg::ht_bucket_cmd_t  lookup;
  logic                    lookup_valid;
  ht_pkg::ht_bucket_cmd_t  walk_cmd;
  ht_pkg::ht_head_t        walk_head;
  logic                    walk_valid;
  logic                    link_valid;
  logic [`HT_BUCKET_W-1:0] link_bucket;
  ht_pkg::ht_head_t        link_head;
  ht_pkg::ht_res_t         done_res;
  logic                    done_valid;
  logic                    clear_busy;

  ht_hash_decode decode_i (
    .clk_i          ( clk_i        ),
    .rst_i          ( rst_i        ),
    .cmd_i          ( cmd_i        ),
    .cmd_valid_i    ( cmd_valid_i  ),
    .cmd_ready_o    ( cmd_ready_o  ),
    .done_i         ( done_valid   ),
    .clear_busy_i   ( clear_busy   ),
    .lookup_o       ( lookup       ),
    .lookup_valid_o ( lookup_valid )
  );

  ht_head_table head_table_i (
    .clk_i          ( clk_i        ),
    .rst_i          ( rst_i        ),
    .lookup_i       ( lookup       ),
    .lookup_valid_i ( lookup_valid ),
    .link_valid_i   ( link_valid   ),
    .link_bucket_i  ( link_bucket  ),
    .link_head_i    ( link_head    ),
    .clear_run_i    ( clear_run_i  ),
    .clear_busy_o   ( clear_busy   ),
    .clear_done_o   ( clear_done_o ),
    .walk_cmd_o     ( walk_cmd     ),
    .walk_head_o    ( walk_head    ),
    .walk_valid_o   ( walk_valid   )
  );

  ht_data_table data_table_i (
    .clk_i          ( clk_i        ),
    .rst_i          ( rst_i        ),
    .walk_cmd_i     ( walk_cmd     ),
    .walk_head_i    ( walk_head    ),
    .walk_valid_i   ( walk_valid   ),
    .clear_run_i    ( clear_run_i  ),
    .link_valid_o   ( link_valid   ),
    .link_bucket_o  ( link_bucket  ),
    .link_head_o    ( link_head    ),
    .done_res_o     ( done_res     ),
    .done_valid_o   ( done_valid   )
  );

  ht_result result_i (
    .clk_i          ( clk_i        ),
    .rst_i          ( rst_i        ),
    .done_res_i     ( done_res     ),
    .done_valid_i   ( done_valid   ),
    .res_o          ( res_o        ),
    .res_valid_o    ( res_valid_o  ),
    .stats_o        ( stats_o      )
  );

endmodule

//--- verilog/ht_result.sv
`timescale 1ns/1ps

module ht_result (
  input  logic              clk_i,
  input  logic              rst_i,

  input  ht_pkg::ht_res_t   done_res_i,
  input  logic              done_valid_i,

  output ht_pkg::ht_res_t   res_o,
  output logic              res_valid_o,

  output ht_pkg::ht_stats_t stats_o
);

  // counters hold at all ones
  function automatic logic [15:0] sat_inc(input logic [15:0] cnt);
    sat_inc = (cnt == '1) ? cnt : cnt + 1'b1;
  endfunction

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      res_valid_o <= 1'b0;
    else
      res_valid_o <= done_valid_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (done_valid_i)
      res_o <= done_res_i;
  end

  // ==========================================================================
  // statistics, updates count as inserts
  // ==========================================================================

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      stats_o <= '0;
    else if (done_valid_i)
    begin
      case (done_res_i.code)
        ht_pkg::FOUND:      stats_o.hits    <= sat_inc(stats_o.hits);
        ht_pkg::NOT_FOUND:  stats_o.misses  <= sat_inc(stats_o.misses);
        ht_pkg::INSERTED,
        ht_pkg::UPDATED:    stats_o.inserts <= sat_inc(stats_o.inserts);
        ht_pkg::TABLE_FULL: stats_o.fulls   <= sat_inc(stats_o.fulls);
        default:            stats_o         <= stats_o;
      endcase
    end
  end

endmodule

//--- verilog/ht_data_table.sv
`timescale 1ns/1ps
`include "ht_cfg.svh"

module ht_data_table (
  input  logic                    clk_i,
  input  logic                    rst_i,

  input  ht_pkg::ht_bucket_cmd_t  walk_cmd_i,
  input  ht_pkg::ht_head_t        walk_head_i,
  input  logic                    walk_valid_i,

  input  logic                    clear_run_i,

  output logic                    link_valid_o,
  output logic [`HT_BUCKET_W-1:0] link_bucket_o,
  output ht_pkg::ht_head_t        link_head_o,

  output ht_pkg::ht_res_t         done_res_o,
  output logic                    done_valid_o
);

  typedef enum logic [1:0] {
    IDLE,
    READ,
    COMPARE,
    WRITE
  } state_e;

  state_e                 state_q;
  state_e                 state_d;

  ht_pkg::ht_bucket_cmd_t cmd_q;
  ht_pkg::ht_head_t       head_q;
  logic [`HT_ADDR_W-1:0]  cur_addr_q;
  logic [`HT_ADDR_W:0]    alloc_q;
  logic                   table_full;

  logic [`HT_ADDR_W-1:0]  rd_addr;
  ht_pkg::ht_entry_t      rd_data;
  logic [`HT_ADDR_W-1:0]  wr_addr_q;
  ht_pkg::ht_entry_t      wr_data_q;
  logic                   new_entry_q;

  logic                   key_match;
  logic                   back_read;
  logic                   at_tail;
  logic                   load_new;
  logic                   load_upd;
  ht_pkg::ht_rescode_e    done_code;
  logic [`HT_VALUE_W-1:0] done_value;

  assign key_match = (rd_data.key == cmd_q.cmd.key);
  assign back_read = (state_q == COMPARE) && !key_match && rd_data.next_ptr_val;

  // empty bucket or last link without a match
  assign at_tail = ((state_q == READ) && !head_q.head_ptr_val) ||
                   ((state_q == COMPARE) && !key_match && !rd_data.next_ptr_val);

  // follow next_ptr straight from the ram output
  assign rd_addr    = back_read ? rd_data.next_ptr : head_q.head_ptr;
  assign table_full = alloc_q[`HT_ADDR_W];

  // ==========================================================================
  // chain walk FSM
  // ==========================================================================

  always_comb
  begin
    state_d      = state_q;
    done_valid_o = 1'b0;
    done_code    = ht_pkg::NOT_FOUND;
    done_value   = '0;
    load_new     = 1'b0;
    load_upd     = 1'b0;

    case (state_q)
      IDLE:
        if (walk_valid_i)
          state_d = READ;
      READ:
        if (head_q.head_ptr_val)
          state_d = COMPARE;
      COMPARE:
        if (key_match)
        begin
          if (cmd_q.cmd.opcode == ht_pkg::SEARCH)
          begin
            done_valid_o = 1'b1;
            done_code    = ht_pkg::FOUND;
            done_value   = rd_data.value;
            state_d      = IDLE;
          end
          else
          begin
            load_upd = 1'b1;
            state_d  = WRITE;
          end
        end
      WRITE:
      begin
        done_valid_o = 1'b1;
        done_code    = new_entry_q ? ht_pkg::INSERTED : ht_pkg::UPDATED;
        done_value   = wr_data_q.value;
        state_d      = IDLE;
      end
      default:
        state_d = IDLE;
    endcase

    if (at_tail)
    begin
      if (cmd_q.cmd.opcode == ht_pkg::SEARCH || table_full)
      begin
        done_valid_o = 1'b1;
        done_code    = table_full && (cmd_q.cmd.opcode == ht_pkg::INSERT) ?
                       ht_pkg::TABLE_FULL : ht_pkg::NOT_FOUND;
        state_d      = IDLE;
      end
      else
      begin
        load_new = 1'b1;
        state_d  = WRITE;
      end
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  // rising allocator, rewound by clear
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      alloc_q <= '0;
    else if (clear_run_i)
      alloc_q <= '0;
    else if (link_valid_o)
      alloc_q <= alloc_q + 1'b1;
  end

  always_ff @(posedge clk_i)
  begin
    if (state_q == IDLE && walk_valid_i)
    begin
      cmd_q  <= walk_cmd_i;
      head_q <= walk_head_i;
    end

    if (state_q == READ)
      cur_addr_q <= head_q.head_ptr;
    else if (back_read)
      cur_addr_q <= rd_data.next_ptr;

    if (load_upd)
    begin
      new_entry_q <= 1'b0;
      wr_addr_q   <= cur_addr_q;
      wr_data_q   <= '{key: rd_data.key, value: cmd_q.cmd.value,
                       next_ptr: rd_data.next_ptr, next_ptr_val: rd_data.next_ptr_val};
    end
    else if (load_new)
    begin
      // new entry goes in front of the old head
      new_entry_q <= 1'b1;
      wr_addr_q   <= alloc_q[`HT_ADDR_W-1:0];
      wr_data_q   <= '{key: cmd_q.cmd.key, value: cmd_q.cmd.value,
                       next_ptr: head_q.head_ptr, next_ptr_val: head_q.head_ptr_val};
    end
  end

  assign link_valid_o  = (state_q == WRITE) && new_entry_q;
  assign link_bucket_o = cmd_q.bucket;
  assign link_head_o   = '{head_ptr: wr_addr_q, head_ptr_val: 1'b1};

  assign done_res_o = '{opcode: cmd_q.cmd.opcode, key: cmd_q.cmd.key,
                        value: done_value, code: done_code};

  ht_dp_ram #(
    .payload_t ( ht_pkg::ht_entry_t ),
    .addr_w    ( `HT_ADDR_W         )
  ) data_ram_i (
    .clk_i     ( clk_i              ),
    .rd_addr_i ( rd_addr            ),
    .rd_data_o ( rd_data            ),
    .wr_en_i   ( state_q == WRITE   ),
    .wr_addr_i ( wr_addr_q          ),
    .wr_data_i ( wr_data_q          )
  );

endmodule

//--- verilog/ht_head_table.sv
`timescale 1ns/1ps
`include "ht_cfg.svh"

module ht_head_table (
  input  logic                    clk_i,
  input  logic                    rst_i,

  input  ht_pkg::ht_bucket_cmd_t  lookup_i,
  input  logic                    lookup_valid_i,

  input  logic                    link_valid_i,
  input  logic [`HT_BUCKET_W-1:0] link_bucket_i,
  input  ht_pkg::ht_head_t        link_head_i,

  input  logic                    clear_run_i,
  output logic                    clear_busy_o,
  output logic                    clear_done_o,

  output ht_pkg::ht_bucket_cmd_t  walk_cmd_o,
  output ht_pkg::ht_head_t        walk_head_o,
  output logic                    walk_valid_o
);

  logic [`HT_BUCKET_W-1:0] clear_addr;
  logic                    wr_en;
  logic [`HT_BUCKET_W-1:0] wr_addr;
  ht_pkg::ht_head_t        wr_data;

  // ==========================================================================
  // clear sweep, one bucket per cycle
  // ==========================================================================

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      clear_busy_o <= 1'b0;
      clear_addr   <= '0;
    end
    else if (clear_run_i)
    begin
      clear_busy_o <= 1'b1;
      clear_addr   <= '0;
    end
    else if (clear_busy_o)
    begin
      clear_addr <= clear_addr + 1'b1;
      if (clear_done_o)
        clear_busy_o <= 1'b0;
    end
  end

  assign clear_done_o = clear_busy_o && (clear_addr == '1);

  // sweep owns the write port, relink otherwise
  assign wr_en   = clear_busy_o || link_valid_i;
  assign wr_addr = clear_busy_o ? clear_addr : link_bucket_i;
  assign wr_data = clear_busy_o ? '0 : link_head_i;

  // ==========================================================================
  // head lookup
  // ==========================================================================

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      walk_valid_o <= 1'b0;
    else
      walk_valid_o <= lookup_valid_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (lookup_valid_i)
      walk_cmd_o <= lookup_i;
  end

  ht_dp_ram #(
    .payload_t ( ht_pkg::ht_head_t ),
    .addr_w    ( `HT_BUCKET_W      )
  ) head_ram_i (
    .clk_i     ( clk_i             ),
    .rd_addr_i ( lookup_i.bucket   ),
    .rd_data_o ( walk_head_o       ),
    .wr_en_i   ( wr_en             ),
    .wr_addr_i ( wr_addr           ),
    .wr_data_i ( wr_data           )
  );

endmodule

//--- verilog/ht_hash_decode.sv
`timescale 1ns/1ps
`include "ht_cfg.svh"

module ht_hash_decode (
  input  logic                   clk_i,
  input  logic                   rst_i,

  input  ht_pkg::ht_cmd_t        cmd_i,
  input  logic                   cmd_valid_i,
  output logic                   cmd_ready_o,

  input  logic                   done_i,
  input  logic                   clear_busy_i,

  output ht_pkg::ht_bucket_cmd_t lookup_o,
  output logic                   lookup_valid_o
);

  localparam int SLICES = `HT_KEY_W / `HT_BUCKET_W;

  logic [`HT_BUCKET_W-1:0] bucket;
  logic                    busy_q;
  logic                    accept;

  // xor fold of the key slices
  always_comb
  begin
    bucket = '0;
    for (int i = 0; i < SLICES; i++)
      bucket = bucket ^ cmd_i.key[i*`HT_BUCKET_W +: `HT_BUCKET_W];
  end

  assign cmd_ready_o = !busy_q && !clear_busy_i;
  assign accept      = cmd_valid_i && cmd_ready_o;

  // one command in flight
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      busy_q         <= 1'b0;
      lookup_valid_o <= 1'b0;
    end
    else
    begin
      lookup_valid_o <= accept;
      if (accept)
        busy_q <= 1'b1;
      else if (done_i)
        busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
      lookup_o <= '{cmd: cmd_i, bucket: bucket};
  end

endmodule

//--- verilog/ht_dp_ram.sv
`timescale 1ns/1ps

module ht_dp_ram #(
  parameter type         payload_t = logic [7:0],
  parameter int unsigned addr_w    = 4
) (
  input  logic              clk_i,

  input  logic [addr_w-1:0] rd_addr_i,
  output payload_t          rd_data_o,

  input  logic              wr_en_i,
  input  logic [addr_w-1:0] wr_addr_i,
  input  payload_t          wr_data_i
);

  localparam int unsigned DEPTH = 1 << addr_w;

  payload_t mem [0:DEPTH-1];

  // write port
  always_ff @(posedge clk_i)
  begin
    if (wr_en_i)
      mem[wr_addr_i] <= wr_data_i;
  end

  // registered read, old data on a same-address collision
  always_ff @(posedge clk_i)
  begin
    rd_data_o <= mem[rd_addr_i];
  end

endmodule

//--- verilog/ht_pkg.sv
`include "ht_cfg.svh"

package ht_pkg;

  typedef enum logic {
    SEARCH = 1'b0,
    INSERT = 1'b1
  } ht_opcode_e;

  typedef struct packed {
    ht_opcode_e              opcode;
    logic [`HT_KEY_W-1:0]    key;
    logic [`HT_VALUE_W-1:0]  value;
  } ht_cmd_t;

  typedef struct packed {
    ht_cmd_t                 cmd;
    logic [`HT_BUCKET_W-1:0] bucket;
  } ht_bucket_cmd_t;

  // head ram word
  typedef struct packed {
    logic [`HT_ADDR_W-1:0]   head_ptr;
    logic                    head_ptr_val;
  } ht_head_t;

  // data ram word, one chain link
  typedef struct packed {
    logic [`HT_KEY_W-1:0]    key;
    logic [`HT_VALUE_W-1:0]  value;
    logic [`HT_ADDR_W-1:0]   next_ptr;
    logic                    next_ptr_val;
  } ht_entry_t;

  typedef enum logic [2:0] {
    FOUND,
    NOT_FOUND,
    INSERTED,
    UPDATED,
    TABLE_FULL
  } ht_rescode_e;

  typedef struct packed {
    ht_opcode_e              opcode;
    logic [`HT_KEY_W-1:0]    key;
    logic [`HT_VALUE_W-1:0]  value;
    ht_rescode_e             code;
  } ht_res_t;

  typedef struct packed {
    logic [15:0]             hits;
    logic [15:0]             misses;
    logic [15:0]             inserts;
    logic [15:0]             fulls;
  } ht_stats_t;

endpackage

//--- verilog/ht_cfg.svh
`ifndef HT_CFG_SVH
`define HT_CFG_SVH

// ============================================================================
// hash table sizing
// ============================================================================

// lookup key
`define HT_KEY_W    32

// stored value
`define HT_VALUE_W  16

// 16 buckets, key must split evenly into bucket-wide slices
`define HT_BUCKET_W 4

// 32 data entries
`define HT_ADDR_W   5

`endif
